/* src/isa_pkg.sv */
package isa_pkg;

    localparam int DATA_WIDTH      = 16;                    // data path and instruction word
    localparam int REG_ADDR_WIDTH  = 3;                     // register index
    localparam int NUM_REGS        = 2 ** REG_ADDR_WIDTH;   // r0 hardwired to zero
    localparam int DMEM_DEPTH      = 64;                    // data memory words
    localparam int DMEM_ADDR_WIDTH = $clog2(DMEM_DEPTH);    // low address bits used
    localparam int OPCODE_WIDTH    = 4;
    localparam int FUNCT_WIDTH     = 3;
    localparam int IMM_WIDTH       = 6;                     // signed immediate of i-type

    typedef logic [DATA_WIDTH-1:0]     data_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_idx_t;

    typedef enum logic [OPCODE_WIDTH-1:0] {
        op_nop  = 4'h0,
        op_alu  = 4'h1,                                     // r-type, funct picks the operation
        op_addi = 4'h2,
        op_lw   = 4'h3,
        op_sw   = 4'h4
    } opcode_e;

    // funct field of r-type, reused as the alu control word
    typedef enum logic [FUNCT_WIDTH-1:0] {
        alu_add = 3'd0,
        alu_sub = 3'd1,
        alu_and = 3'd2,
        alu_or  = 3'd3,
        alu_xor = 3'd4,
        alu_slt = 3'd5                                      // signed compare
    } alu_func_e;

    typedef struct packed {
        opcode_e   opcode;
        reg_idx_t  rd;
        reg_idx_t  rs1;
        reg_idx_t  rs2;
        alu_func_e funct;
    } r_instr_t;

    typedef struct packed {
        opcode_e                opcode;
        reg_idx_t               rd_rs2;                     // rd for addi/lw, rs2 for sw
        reg_idx_t               rs1;                        // base for lw/sw
        logic [IMM_WIDTH-1:0]   imm6;
    } i_instr_t;

    typedef union packed {
        r_instr_t r;
        i_instr_t i;
    } instr_u;

endpackage

/* src/pipe_pkg.sv */
package pipe_pkg;
    import isa_pkg::*;

    localparam int HAZD_WIDTH     = 2;
    localparam int HAZD_HOLD_BIT  = 0;                      // discard id result, keep id/ex
    localparam int HAZD_NO_OP_BIT = 1;                      // ex does nothing this cycle

    typedef struct packed {
        logic read;                                         // load
        logic write;                                        // store
    } mem_ctrl_t;

    typedef struct packed {
        logic      reg_write_enable;
        mem_ctrl_t mem_ctrl;
        alu_func_e alu_control;
        data_t     operand_1;                               // rs1 value
        data_t     operand_2;                               // rs2 value or sign-extended imm
        data_t     store_data;                              // rs2 value for sw
        reg_idx_t  reg_1_idx;                               // zero when rs1 unused
        reg_idx_t  reg_2_idx;                               // zero when rs2 unused
        reg_idx_t  reg_dest_idx;
    } id_ex_t;

    typedef struct packed {
        logic      valid;
        logic      reg_write_enable;
        mem_ctrl_t mem_ctrl;
        data_t     alu_result;                              // also the memory address
        data_t     store_data;
        reg_idx_t  reg_dest_idx;
    } ex_mem_t;

    typedef struct packed {
        logic     valid;                                    // never set for r0
        reg_idx_t dest;
        data_t    data;
    } wb_t;

    typedef enum logic [1:0] {
        fwd_none = 2'd0,
        fwd_mem  = 2'd1,
        fwd_wb   = 2'd2
    } fwd_sel_e;

endpackage

/* src/decode_unit.sv */
`timescale 1ns/1ns

module decode_unit (
    input  isa_pkg::instr_u   instr,
    input  logic              instr_valid,
    input  isa_pkg::data_t    rd_data_1,                    // from reg_file
    input  isa_pkg::data_t    rd_data_2,
    output isa_pkg::reg_idx_t rd_idx_1,                     // to reg_file and hazard_unit
    output isa_pkg::reg_idx_t rd_idx_2,
    output logic              id_no_op,                     // idle input becomes a bubble
    output pipe_pkg::id_ex_t  id_payload
);
    import isa_pkg::*;
    import pipe_pkg::*;

    opcode_e   opcode;                                      // same bits in both views
    data_t     imm_ext;
    logic      use_imm;                                     // operand_2 from imm
    logic      write_en;
    mem_ctrl_t mem_ctrl;
    alu_func_e alu_ctrl;
    reg_idx_t  dest_idx;

    assign opcode   = instr.r.opcode;
    assign id_no_op = ~instr_valid;
    assign imm_ext  = {{(DATA_WIDTH - IMM_WIDTH){instr.i.imm6[IMM_WIDTH-1]}}, instr.i.imm6};

    // control unit and index mux
    always_comb begin
        rd_idx_1 = '0;                                      // r0 never causes a stall
        rd_idx_2 = '0;
        use_imm  = 1'b1;
        write_en = 1'b0;
        mem_ctrl = '0;
        alu_ctrl = alu_add;                                 // address add for lw/sw
        dest_idx = '0;
        if (instr_valid) begin
            case (opcode)
                op_alu: begin
                    rd_idx_1 = instr.r.rs1;
                    rd_idx_2 = instr.r.rs2;
                    use_imm  = 1'b0;
                    write_en = 1'b1;
                    alu_ctrl = instr.r.funct;
                    dest_idx = instr.r.rd;
                end
                op_addi, op_lw: begin
                    rd_idx_1      = instr.i.rs1;
                    write_en      = 1'b1;
                    mem_ctrl.read = (opcode == op_lw);
                    dest_idx      = instr.i.rd_rs2;
                end
                op_sw: begin
                    rd_idx_1       = instr.i.rs1;
                    rd_idx_2       = instr.i.rd_rs2;        // store data register
                    mem_ctrl.write = 1'b1;
                end
                default: ;                                  // nop and unused codes
            endcase
        end
    end

    assign id_payload = '{
        reg_write_enable: write_en,
        mem_ctrl:         mem_ctrl,
        alu_control:      alu_ctrl,
        operand_1:        rd_data_1,
        operand_2:        use_imm ? imm_ext : rd_data_2,
        store_data:       rd_data_2,
        reg_1_idx:        rd_idx_1,
        reg_2_idx:        rd_idx_2,
        reg_dest_idx:     dest_idx
    };

endmodule

/* src/reg_file.sv */
`timescale 1ns/1ns

module reg_file (
    input  logic              clk,
    input  logic              rst_n,
    input  isa_pkg::reg_idx_t rd_idx_1,
    input  isa_pkg::reg_idx_t rd_idx_2,
    output isa_pkg::data_t    rd_data_1,
    output isa_pkg::data_t    rd_data_2,
    input  pipe_pkg::wb_t     wb                            // write port
);
    import isa_pkg::*;

    data_t regs [NUM_REGS];
    logic  wr_en;                                           // r0 is never written

    assign wr_en = wb.valid && (wb.dest != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            regs <= '{default: '0};
        end else if (wr_en) begin
            regs[wb.dest] <= wb.data;
        end
    end

    // write-through so id sees a value in the cycle it is written
    assign rd_data_1 = (wr_en && wb.dest == rd_idx_1) ? wb.data : regs[rd_idx_1];
    assign rd_data_2 = (wr_en && wb.dest == rd_idx_2) ? wb.data : regs[rd_idx_2];

    a_r0_reads_zero: assert property (@(posedge clk) disable iff (!rst_n)
        (rd_idx_1 == '0 -> rd_data_1 == '0) && (rd_idx_2 == '0 -> rd_data_2 == '0));

endmodule

/* src/id_ex_reg.sv */
`timescale 1ns/1ns

module id_ex_reg (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic [pipe_pkg::HAZD_WIDTH-1:0]    hazard_control,  // from hazard_unit
    input  logic                               id_no_op,        // idle input
    input  pipe_pkg::id_ex_t                   id_payload,      // from decode_unit
    output logic                               ex_no_op,        // bubble in ex
    output pipe_pkg::id_ex_t                   ex_payload       // to ex_stage and forwarding
);
    import pipe_pkg::*;

    logic hold;

    assign hold = hazard_control[HAZD_HOLD_BIT];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_payload <= '0;                               // no write, no memory access
            ex_no_op   <= 1'b0;
        end else begin
            if (!hold) begin
                ex_payload <= id_payload;                   // held payload stays for replay
            end
            ex_no_op <= hazard_control[HAZD_NO_OP_BIT] | id_no_op;
        end
    end

    // a stalled load keeps its payload, the bubble behind it is marked by ex_no_op
    a_hold_keeps_payload: assert property (@(posedge clk) disable iff (!rst_n)
        hold |=> $stable(ex_payload));

endmodule

/* src/hazard_unit.sv */
`timescale 1ns/1ns

module hazard_unit (
    input  logic                            clk,            // assertion sampling only
    input  logic                            rst_n,
    input  logic                            ex_mem_read,    // load in ex
    input  isa_pkg::reg_idx_t               ex_dest_idx,
    input  logic                            ex_no_op,
    input  isa_pkg::reg_idx_t               id_idx_1,
    input  isa_pkg::reg_idx_t               id_idx_2,
    input  logic                            id_uses_rs2,
    output logic [pipe_pkg::HAZD_WIDTH-1:0] hazard_control,
    output logic                            instr_ready
);
    import pipe_pkg::*;

    logic load_in_ex;
    logic load_use;

    assign load_in_ex = ex_mem_read && !ex_no_op && (ex_dest_idx != '0);
    assign load_use   = load_in_ex &&
                        ((ex_dest_idx == id_idx_1) ||
                         (id_uses_rs2 && ex_dest_idx == id_idx_2));

    assign hazard_control[HAZD_HOLD_BIT]  = load_use;
    assign hazard_control[HAZD_NO_OP_BIT] = load_use;  // bubble behind the load
    assign instr_ready                    = ~hazard_control[HAZD_HOLD_BIT];

    // the bubble clears the hazard, so a stall is one cycle long
    a_stall_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
        hazard_control[HAZD_HOLD_BIT] |=> !hazard_control[HAZD_HOLD_BIT]);

endmodule

/* src/forwarding_unit.sv */
`timescale 1ns/1ns

module forwarding_unit (
    input  isa_pkg::reg_idx_t  ex_idx_1,
    input  isa_pkg::reg_idx_t  ex_idx_2,
    input  pipe_pkg::ex_mem_t  mem_stage,                   // one instruction ahead
    input  pipe_pkg::wb_t      wb,                          // two instructions ahead
    output pipe_pkg::fwd_sel_e fwd_sel_1,
    output pipe_pkg::fwd_sel_e fwd_sel_2
);
    import isa_pkg::*;
    import pipe_pkg::*;

    logic mem_writes;                                       // alu result ready in mem

    // a load in mem can't be a source, the stall keeps it out
    assign mem_writes = mem_stage.valid && mem_stage.reg_write_enable &&
                        !mem_stage.mem_ctrl.read;

    function automatic fwd_sel_e pick_source(reg_idx_t idx);
        fwd_sel_e sel;
        sel = fwd_none;
        if (idx != '0) begin
            if (mem_writes && mem_stage.reg_dest_idx == idx) begin
                sel = fwd_mem;                              // most recent writer wins
            end else if (wb.valid && wb.dest == idx) begin
                sel = fwd_wb;
            end
        end
        return sel;
    endfunction

    assign fwd_sel_1 = pick_source(ex_idx_1);
    assign fwd_sel_2 = pick_source(ex_idx_2);

endmodule

/* src/ex_stage.sv */
`timescale 1ns/1ns

module ex_stage (
    input  logic               ex_no_op,
    input  pipe_pkg::id_ex_t   ex_payload,
    input  pipe_pkg::fwd_sel_e fwd_sel_1,
    input  pipe_pkg::fwd_sel_e fwd_sel_2,
    input  isa_pkg::data_t     mem_fwd_data,                // alu result in mem
    input  isa_pkg::data_t     wb_fwd_data,                 // wb stream data
    output pipe_pkg::ex_mem_t  ex_result
);
    import isa_pkg::*;
    import pipe_pkg::*;

    data_t alu_a;
    data_t alu_b;
    data_t rs2_value;                                       // forwarded rs2
    data_t alu_y;

    function automatic data_t fwd_mux(fwd_sel_e sel, data_t id_value);
        case (sel)
            fwd_mem: return mem_fwd_data;
            fwd_wb:  return wb_fwd_data;
            default: return id_value;
        endcase
    endfunction

    assign alu_a     = fwd_mux(fwd_sel_1, ex_payload.operand_1);
    assign rs2_value = fwd_mux(fwd_sel_2, ex_payload.store_data);
    // sw keeps its offset here, rs2 only feeds the store data
    assign alu_b     = ex_payload.mem_ctrl.write ? ex_payload.operand_2
                                                 : fwd_mux(fwd_sel_2, ex_payload.operand_2);

    always_comb begin
        case (ex_payload.alu_control)
            alu_add: alu_y = alu_a + alu_b;                 // also lw/sw address
            alu_sub: alu_y = alu_a - alu_b;                 // wraps mod 2^16
            alu_and: alu_y = alu_a & alu_b;
            alu_or:  alu_y = alu_a | alu_b;
            alu_xor: alu_y = alu_a ^ alu_b;
            alu_slt: alu_y = {{(DATA_WIDTH - 1){1'b0}}, $signed(alu_a) < $signed(alu_b)};
            default: alu_y = '0;
        endcase
    end

    assign ex_result = '{
        valid:            ~ex_no_op,                        // bubble carries nothing
        reg_write_enable: ex_payload.reg_write_enable,
        mem_ctrl:         ex_payload.mem_ctrl,
        alu_result:       alu_y,
        store_data:       rs2_value,
        reg_dest_idx:     ex_payload.reg_dest_idx
    };

endmodule

/* src/mem_wb_stage.sv */
`timescale 1ns/1ns

module mem_wb_stage (
    input  logic              clk,
    input  logic              rst_n,
    input  pipe_pkg::ex_mem_t ex_result,                    // from ex_stage
    output pipe_pkg::ex_mem_t mem_stage,                    // ex/mem register
    output pipe_pkg::wb_t     wb                            // mem/wb register
);
    import isa_pkg::*;
    import pipe_pkg::*;

    data_t                      dmem [DMEM_DEPTH];
    logic [DMEM_ADDR_WIDTH-1:0] wr_addr;
    logic [DMEM_ADDR_WIDTH-1:0] rd_addr;
    data_t                      load_data;

    assign wr_addr = ex_result.alu_result[DMEM_ADDR_WIDTH-1:0];
    assign rd_addr = mem_stage.alu_result[DMEM_ADDR_WIDTH-1:0];

    // ex/mem register
    always_ff @(posedge clk) begin
        mem_stage <= ex_result;
        if (!rst_n) begin
            mem_stage.valid <= 1'b0;
        end
    end

    // store lands at the ex/mem edge so a load right behind sees it
    always_ff @(posedge clk) begin
        if (ex_result.valid && ex_result.mem_ctrl.write) begin
            dmem[wr_addr] <= ex_result.store_data;
        end
    end

    assign load_data = dmem[rd_addr];                       // async read

    // mem/wb register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb.valid <= 1'b0;
        end else begin
            wb.valid <= mem_stage.valid && mem_stage.reg_write_enable &&
                        (mem_stage.reg_dest_idx != '0);     // r0 writes dropped
        end
        wb.dest <= mem_stage.reg_dest_idx;
        wb.data <= mem_stage.mem_ctrl.read ? load_data : mem_stage.alu_result;
    end

    // decode never pairs a store with a register write
    a_store_no_write: assert property (@(posedge clk) disable iff (!rst_n)
        (mem_stage.valid && mem_stage.mem_ctrl.write) |-> !mem_stage.reg_write_enable);

endmodule

/* src/pipeline_top.sv */
`timescale 1ns/1ns

module pipeline_top (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            instr_valid,
    input  isa_pkg::instr_u instr,
    output logic            instr_ready,
    output pipe_pkg::wb_t   wb
);
    import isa_pkg::*;
    import pipe_pkg::*;

    reg_idx_t              rd_idx_1;
    reg_idx_t              rd_idx_2;
    data_t                 rd_data_1;
    data_t                 rd_data_2;
    logic                  id_no_op;
    logic                  ex_no_op;
    id_ex_t                id_payload;
    id_ex_t                ex_payload;
    logic [HAZD_WIDTH-1:0] hazard_control;
    fwd_sel_e              fwd_sel_1;
    fwd_sel_e              fwd_sel_2;
    ex_mem_t               ex_result;
    ex_mem_t               mem_stage;

    decode_unit u_decode (
        .instr, .instr_valid, .rd_data_1, .rd_data_2,
        .rd_idx_1, .rd_idx_2, .id_no_op, .id_payload
    );

    reg_file u_reg_file (
        .clk, .rst_n, .rd_idx_1, .rd_idx_2, .rd_data_1, .rd_data_2, .wb
    );

    hazard_unit u_hazard (
        .clk, .rst_n,
        .ex_mem_read    (ex_payload.mem_ctrl.read),
        .ex_dest_idx    (ex_payload.reg_dest_idx),
        .ex_no_op,
        .id_idx_1       (rd_idx_1),
        .id_idx_2       (rd_idx_2),
        .id_uses_rs2    (id_payload.reg_2_idx != '0),       // zeroed by decode when unused
        .hazard_control, .instr_ready
    );

    id_ex_reg u_id_ex (
        .clk, .rst_n, .hazard_control, .id_no_op, .id_payload, .ex_no_op, .ex_payload
    );

    forwarding_unit u_forward (
        .ex_idx_1 (ex_payload.reg_1_idx),
        .ex_idx_2 (ex_payload.reg_2_idx),
        .mem_stage, .wb, .fwd_sel_1, .fwd_sel_2
    );

    ex_stage u_ex (
        .ex_no_op, .ex_payload, .fwd_sel_1, .fwd_sel_2,
        .mem_fwd_data (mem_stage.alu_result),
        .wb_fwd_data  (wb.data),
        .ex_result
    );

    mem_wb_stage u_mem_wb (
        .clk, .rst_n, .ex_result, .mem_stage, .wb
    );

endmodule

/* testbench/tb_clock_gen.sv */
`timescale 1ns/1ns

module tb_clock_gen (
    output logic clk
);
    localparam int HALF_PERIOD_NS = 20;                     // 40 ns period

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule

/* testbench/pipeline_tb.sv */
`timescale 1ns/1ns

module pipeline_tb;
    import isa_pkg::*;
    import pipe_pkg::*;

    localparam int TABLE_LEN   = 20;
    localparam int RAND_COUNT  = 40;
    localparam int CYCLE_LIMIT = 3 * (TABLE_LEN + RAND_COUNT) + 50;

    typedef struct {
        string    name;
        instr_u   word;
        bit       has_ev;                                   // false for stores and r0 writes
        reg_idx_t dest;
        data_t    data;
        int       stalls;                                   // cycles with instr_ready low
    } test_t;

    typedef struct {
        string    name;
        bit       has_ev;
        reg_idx_t dest;
        data_t    data;
        int       stalls;
        int       waited;                                   // stall cycles actually seen
        int       due;                                      // cycle count when wb shows it
    } exp_t;

    logic        clk;
    logic        rst_n;
    logic        instr_valid;
    instr_u      instr;
    logic        instr_ready;
    wb_t         wb;
    test_t       tests[$];
    exp_t        exp_q[$];                                  // in issue order
    data_t       model_regs [NUM_REGS];
    data_t       model_mem [DMEM_DEPTH];
    bit          mem_known [DMEM_DEPTH];                    // word stored at least once
    logic [31:0] rng;
    bit          prev_load;                                 // last accepted was lw
    reg_idx_t    prev_dest;
    int          cycle = 0;
    int          passed = 0;
    int          failed = 0;
    int          ev_seen = 0;
    int          ev_expected = 0;

    tb_clock_gen clk_gen_i (.clk);

    pipeline_top pipeline_top_i (.clk, .rst_n, .instr_valid, .instr, .instr_ready, .wb);

    always @(posedge clk) cycle <= cycle + 1;

    function automatic logic [31:0] xorshift32(logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic instr_u r_word(alu_func_e f, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return {op_alu, rd, rs1, rs2, f};
    endfunction

    function automatic instr_u i_word(opcode_e op, reg_idx_t rd_rs2, reg_idx_t rs1,
                                      logic [IMM_WIDTH-1:0] imm);
        return {op, rd_rs2, rs1, imm};
    endfunction

    function automatic data_t sext6(logic [IMM_WIDTH-1:0] v);
        return {{(DATA_WIDTH - IMM_WIDTH){v[IMM_WIDTH-1]}}, v};
    endfunction

    function automatic data_t alu_expected(alu_func_e f, data_t a, data_t b);
        case (f)
            alu_add: return a + b;
            alu_sub: return a - b;                          // wraps mod 2^16
            alu_and: return a & b;
            alu_or:  return a | b;
            alu_xor: return a ^ b;
            default: return ($signed(a) < $signed(b)) ? 16'd1 : 16'd0;
        endcase
    endfunction

    // a load right before that feeds rs1, or rs2 of alu/sw, costs one cycle
    function automatic int stalls_expected(instr_u w);
        reg_idx_t rs2;
        bit       uses_rs2;
        rs2      = (w.r.opcode == op_sw) ? w.i.rd_rs2 : w.r.rs2;
        uses_rs2 = (w.r.opcode == op_alu) || (w.r.opcode == op_sw);
        return (prev_load && prev_dest != '0 &&
                (w.r.rs1 == prev_dest || (uses_rs2 && rs2 == prev_dest))) ? 1 : 0;
    endfunction

    // architectural model in program order, gives the wb event
    task automatic execute_model(input instr_u w, output bit has_ev, output reg_idx_t dest,
                                 output data_t data);
        data_t base;
        data_t addr;
        base   = model_regs[w.i.rs1];
        addr   = base + sext6(w.i.imm6);
        has_ev = (w.i.opcode != op_sw);
        dest   = w.i.rd_rs2;                                // same bits as r.rd
        case (w.r.opcode)
            op_alu:  data = alu_expected(w.r.funct, base, model_regs[w.r.rs2]);
            op_addi: data = addr;
            op_lw:   data = model_mem[addr[DMEM_ADDR_WIDTH-1:0]];
            default: begin
                data = model_regs[w.i.rd_rs2];
                model_mem[addr[DMEM_ADDR_WIDTH-1:0]] = data;
                mem_known[addr[DMEM_ADDR_WIDTH-1:0]] = 1'b1;
            end
        endcase
        has_ev = has_ev && (dest != '0);
        if (has_ev) model_regs[dest] = data;
    endtask

    task automatic add_test(string name, instr_u word, bit has_ev, reg_idx_t dest, data_t data,
                            int stalls);
        tests.push_back('{name, word, has_ev, dest, data, stalls});
    endtask

    // name, instruction, wb event, dest, data, stall cycles
    task automatic build_table();
        add_test("addi r1 5", i_word(op_addi, 3'd1, 3'd0, 6'h05), 1, 3'd1, 16'h0005, 0);
        add_test("addi r2 -3", i_word(op_addi, 3'd2, 3'd0, 6'h3d), 1, 3'd2, 16'hfffd, 0);
        add_test("add mem+wb fwd", r_word(alu_add, 3'd3, 3'd1, 3'd2), 1, 3'd3, 16'h0002, 0);
        add_test("sub", r_word(alu_sub, 3'd4, 3'd1, 3'd2), 1, 3'd4, 16'h0008, 0);
        add_test("sub wraps", r_word(alu_sub, 3'd5, 3'd0, 3'd1), 1, 3'd5, 16'hfffb, 0);
        add_test("and", r_word(alu_and, 3'd6, 3'd2, 3'd5), 1, 3'd6, 16'hfff9, 0);
        add_test("or", r_word(alu_or, 3'd7, 3'd1, 3'd4), 1, 3'd7, 16'h000d, 0);
        add_test("xor mem fwd", r_word(alu_xor, 3'd3, 3'd7, 3'd2), 1, 3'd3, 16'hfff0, 0);
        add_test("slt signed 1", r_word(alu_slt, 3'd4, 3'd2, 3'd1), 1, 3'd4, 16'h0001, 0);
        add_test("slt signed 0", r_word(alu_slt, 3'd5, 3'd1, 3'd2), 1, 3'd5, 16'h0000, 0);
        add_test("addi to r0", i_word(op_addi, 3'd0, 3'd1, 6'h07), 0, 3'd0, 16'h0000, 0);
        add_test("r0 reads zero", r_word(alu_add, 3'd6, 3'd0, 3'd1), 1, 3'd6, 16'h0005, 0);
        add_test("sw to 8", i_word(op_sw, 3'd3, 3'd1, 6'h03), 0, 3'd0, 16'h0000, 0);
        add_test("addi base 12", i_word(op_addi, 3'd2, 3'd0, 6'h0c), 1, 3'd2, 16'h000c, 0);
        add_test("lw from 8", i_word(op_lw, 3'd7, 3'd2, 6'h3c), 1, 3'd7, 16'hfff0, 0);
        add_test("load-use rs1", r_word(alu_add, 3'd3, 3'd7, 3'd1), 1, 3'd3, 16'hfff5, 1);
        add_test("sw fwd data", i_word(op_sw, 3'd3, 3'd0, 6'h00), 0, 3'd0, 16'h0000, 0);
        add_test("lw after sw", i_word(op_lw, 3'd5, 3'd0, 6'h00), 1, 3'd5, 16'hfff5, 0);
        add_test("load-use rs2", r_word(alu_sub, 3'd1, 3'd1, 3'd5), 1, 3'd1, 16'h0010, 1);
        add_test("wb fwd of load", r_word(alu_xor, 3'd2, 3'd5, 3'd1), 1, 3'd2, 16'hffe5, 0);
    endtask

    // random alu, addi, lw or sw with the model giving its expected event
    task automatic random_test(input int n, output test_t t);
        instr_u   w;
        data_t    addr;
        bit       ev;
        reg_idx_t dest;
        data_t    data;
        rng = xorshift32(rng);
        case (rng[1:0])
            2'd0:    w = r_word(alu_func_e'(rng[4:2] % 3'd6), rng[7:5], rng[10:8], rng[13:11]);
            2'd1:    w = i_word(op_addi, rng[7:5], rng[10:8], rng[19:14]);
            2'd2:    w = i_word(op_lw, rng[7:5], rng[10:8], rng[19:14]);
            default: w = i_word(op_sw, rng[7:5], rng[10:8], rng[19:14]);
        endcase
        addr = model_regs[w.i.rs1] + sext6(w.i.imm6);
        if (w.i.opcode == op_lw && !mem_known[addr[DMEM_ADDR_WIDTH-1:0]]) begin
            w.i.opcode = op_sw;                             // memory has no reset, store first
        end
        t.name   = $sformatf("random %0d", n);
        t.word   = w;
        t.stalls = stalls_expected(w);
        execute_model(w, ev, dest, data);
        t.has_ev = ev;
        t.dest   = dest;
        t.data   = data;
    endtask

    // drive from a falling edge, hold until accepted at a rising edge
    task automatic issue(input test_t t);
        int waited;
        waited      = 0;
        instr_valid = 1'b1;
        instr       = t.word;
        @(posedge clk);
        while (!instr_ready) begin
            waited++;
            @(posedge clk);
        end
        exp_q.push_back('{t.name, t.has_ev, t.dest, t.data, t.stalls, waited, cycle + 3});
        if (t.has_ev) ev_expected++;
        prev_load = (t.word.r.opcode == op_lw);
        prev_dest = t.word.i.rd_rs2;
        @(negedge clk);
    endtask

    // one line per test when its wb slot comes up
    task automatic check_event(input exp_t e);
        if (e.waited != e.stalls) begin
            failed++;
            $display("FAILED %s stall cycles expected %0d actual %0d", e.name, e.stalls, e.waited);
        end else if (e.has_ev && wb.valid !== 1'b1) begin
            failed++;
            $display("FAILED %s expected r%0d=%h actual no wb event", e.name, e.dest, e.data);
        end else if (e.has_ev && (wb.dest !== e.dest || wb.data !== e.data)) begin
            failed++;
            $display("FAILED %s expected r%0d=%h actual r%0d=%h", e.name, e.dest, e.data,
                     wb.dest, wb.data);
        end else if (!e.has_ev && wb.valid) begin
            failed++;
            $display("FAILED %s expected no wb event actual r%0d=%h", e.name, wb.dest, wb.data);
        end else begin
            passed++;
            $display("ok     %s", e.name);
        end
    endtask

    // wb is stable here, each event is seen once at its fixed latency
    always @(negedge clk) begin
        if (wb.valid) ev_seen++;
        if (exp_q.size() > 0 && exp_q[0].due == cycle) begin
            check_event(exp_q.pop_front());
        end else if (wb.valid) begin
            failed++;
            $display("wb event r%0d=%h arrived with no instruction due", wb.dest, wb.data);
        end
    end

    initial begin
        wait (cycle >= CYCLE_LIMIT);
        $display("timeout after %0d cycles, pipeline stopped accepting or retiring", CYCLE_LIMIT);
        $display("TB FAILED");
        $finish;
    end

    initial begin
        test_t    t;
        bit       ev;
        reg_idx_t dest;
        data_t    data;
        instr_valid = 1'b0;
        instr       = '0;
        rst_n       = 1'b0;
        rng         = 32'h5be2;
        prev_load   = 1'b0;
        prev_dest   = '0;
        model_regs  = '{default: '0};
        mem_known   = '{default: 1'b0};
        build_table();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        foreach (tests[k]) begin
            execute_model(tests[k].word, ev, dest, data);  // keep model in step with table
            issue(tests[k]);
        end
        for (int n = 0; n < RAND_COUNT; n++) begin
            random_test(n, t);
            issue(t);
        end
        instr_valid = 1'b0;
        while (exp_q.size() > 0) @(negedge clk);
        repeat (3) @(negedge clk);                          // catch stray events
        @(posedge clk);
        if (ev_seen != ev_expected) begin
            failed++;
            $display("wb event count %0d does not match %0d register writes issued",
                     ev_seen, ev_expected);
        end
        $display("tests %0d passed %0d failed %0d wb events %0d", TABLE_LEN + RAND_COUNT,
                 passed, failed, ev_seen);
        if (failed == 0 && passed == TABLE_LEN + RAND_COUNT) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* flist.f */
src/isa_pkg.sv
src/pipe_pkg.sv
src/decode_unit.sv
src/reg_file.sv
src/id_ex_reg.sv
src/hazard_unit.sv
src/forwarding_unit.sv
src/ex_stage.sv
src/mem_wb_stage.sv
src/pipeline_top.sv
testbench/tb_clock_gen.sv
testbench/pipeline_tb.sv
